// File: lane_tally.sv
`include "vote_defs.svh"

`default_nettype none

module lane_tally #(
    // cores handled by this half
    parameter int LANES = `VT_CORES / 2
) (
    input  wire               clk,
    input  wire               rst,
    input  wire [LANES-1:0]   store,
    input  wire [LANES-1:0]   result,
    // registered, one cycle after the inputs
    output vote_pkg::partial_t partial
);

    localparam int PW = $bits(vote_pkg::partial_t);

    // per core vote, +1 / -1 / 0
    logic signed [1:0] vote [LANES];

    // combinational sum of this half
    logic signed [PW-1:0] vote_sum;

    // vote selector
    // stored one -> +1, stored zero -> -1, not stored -> 0
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (!store[i]) begin
                vote[i] = 2'sd0;
            end else if (result[i]) begin
                vote[i] = 2'sd1;
            end else begin
                vote[i] = -2'sd1;
            end
        end
    end

    // adder chain
    // size cast keeps the sign, so -1 extends correctly
    always_comb begin
        vote_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            vote_sum = vote_sum + PW'(vote[i]);
        end
    end

    // partial register, taken every cycle
    // the accumulator decides whether it counts
    always_ff @(posedge clk) begin
        if (rst) begin
            partial.sum <= '0;
        end else begin
            partial.sum <= vote_sum;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
vote_pkg.sv
vote_credit_fifo.sv
lane_tally.sv
vote_accumulator.sv
vote_tally_top.sv
vote_tally_sva.sv
tb_vote_tally.sv

// File: run_sim.sh
#!/bin/sh
# build and run the vote tally testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
SIM=sim_vote_tally

# compile, warnings are printed but do not stop the build
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_vote_tally -Mdir "$BUILD_DIR" -o "$SIM"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# run, keep the output for the pass search
"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb_vote_tally.sv
`include "vote_defs.svh"

module tb_vote_tally;

    localparam int DEPTH = `VT_FIFO_DEPTH;
    localparam int MASK_GROUPS = 20;
    localparam int RAND_GROUPS = 8;
    localparam int MAX_GROUP_LEN = 12;
    localparam int BURST_LEN = 10;
    // upper bound on batches over all tests
    localparam int MAX_BATCHES = 2 + MASK_GROUPS + RAND_GROUPS * MAX_GROUP_LEN + BURST_LEN;
    localparam int WATCHDOG_CYCLES = MAX_BATCHES * 20 + 500;

    logic                    clk;
    logic                    rst;
    logic                    batch_valid;
    vote_pkg::vote_batch_t   batch;
    logic                    credit;
    logic                    result_valid;
    vote_pkg::tally_result_t result;

    // sender side state
    int credits;
    int credit_pulses;
    int sent_count;
    int mismatches;
    int other_errors;

    vote_pkg::vote_batch_t   send_q [$];
    vote_pkg::tally_result_t exp_q [$];

    vote_tally_top vote_tally_top_inst (
        .clk          (clk),
        .rst          (rst),
        .batch_valid  (batch_valid),
        .batch        (batch),
        .credit       (credit),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hard stop if the DUT stalls
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check_value(string what, longint got, longint exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // reference vote rule
    // stored one counts +1 and stored zero -1, unstored cores count nothing
    function automatic int batch_votes(vote_pkg::vote_batch_t b);
        int sum;
        sum = 0;
        for (int i = 0; i < `VT_CORES; i++) begin
            if (b.store[i]) begin
                sum += b.result[i] ? 1 : -1;
            end
        end
        return sum;
    endfunction

    function automatic vote_pkg::tally_result_t make_expected(int total, int count);
        vote_pkg::tally_result_t r;
        r.total = `VT_ACC_W'(total);
        r.sign  = (total < 0);
        r.count = `VT_CNT_W'(count);
        return r;
    endfunction

    task automatic check_result(vote_pkg::tally_result_t got);
        vote_pkg::tally_result_t exp;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("error at %0t: result pulse with no group outstanding", $time);
        end else begin
            exp = exp_q.pop_front();
            check_value("total", longint'(got.total), longint'(exp.total));
            check_value("sign", longint'(got.sign), longint'(exp.sign));
            check_value("count", longint'(got.count), longint'(exp.count));
        end
    endtask

    // outputs sampled at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (credit) begin
                    credits++;
                    credit_pulses++;
                end
                if (result_valid) begin
                    check_result(result);
                end
            end
        end
    end

    // one batch per cycle while credits last
    task automatic send_queue();
        while (send_q.size() > 0) begin
            @(posedge clk);
            #1;
            if (credits > 0) begin
                batch       = send_q.pop_front();
                batch_valid = 1'b1;
                credits--;
                sent_count++;
            end else begin
                batch_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        batch_valid = 1'b0;
    endtask

    task automatic wait_results(int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            other_errors++;
            $display("error at %0t: %0d group results never arrived", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    // random group with its model total built alongside
    task automatic queue_random_group(int len);
        vote_pkg::vote_batch_t b;
        int total;
        total = 0;
        for (int i = 0; i < len; i++) begin
            b.store  = `VT_CORES'($urandom);
            b.result = `VT_CORES'($urandom);
            b.last   = (i == len - 1);
            total += batch_votes(b);
            send_q.push_back(b);
        end
        exp_q.push_back(make_expected(total, len));
    endtask

    task automatic test_reset_state();
        repeat (8) begin
            @(negedge clk);
            check_value("credit after reset", longint'(credit), 0);
            check_value("result_valid after reset", longint'(result_valid), 0);
        end
    endtask

    task automatic test_unanimous();
        vote_pkg::vote_batch_t b;
        b.store  = '1;
        b.result = '1;
        b.last   = 1'b1;
        send_q.push_back(b);
        exp_q.push_back(make_expected(`VT_CORES, 1));
        b.result = '0;
        send_q.push_back(b);
        exp_q.push_back(make_expected(-`VT_CORES, 1));
        send_queue();
        wait_results(100);
    endtask

    task automatic test_masked();
        for (int g = 0; g < MASK_GROUPS; g++) begin
            queue_random_group(1);
        end
        send_queue();
        wait_results(MASK_GROUPS * 20 + 50);
    endtask

    task automatic test_random_groups();
        int n;
        n = 0;
        for (int g = 0; g < RAND_GROUPS; g++) begin
            queue_random_group(int'($urandom_range(MAX_GROUP_LEN, 1)));
        end
        n = send_q.size();
        send_queue();
        wait_results(n * 20 + 50);
    endtask

    task automatic test_credit_burst();
        int start_pulses;
        int start_sent;
        start_pulses = credit_pulses;
        start_sent   = sent_count;
        queue_random_group(BURST_LEN);
        send_queue();
        wait_results(BURST_LEN * 20 + 50);
        check_value("credits after burst", longint'(credits), longint'(DEPTH));
        check_value("credit pulses in burst", longint'(credit_pulses - start_pulses),
                    longint'(sent_count - start_sent));
    endtask

    initial begin
        void'($urandom(32'hac1c954a));
        rst           = 1'b1;
        batch_valid   = 1'b0;
        batch         = '0;
        credits       = DEPTH;
        credit_pulses = 0;
        sent_count    = 0;
        mismatches    = 0;
        other_errors  = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_unanimous();
        test_masked();
        test_random_groups();
        test_credit_burst();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vote_accumulator.sv
`include "vote_defs.svh"

`default_nettype none

module vote_accumulator (
    input  wire                 clk,
    input  wire                 rst,
    // control straight from the fifo pop
    input  wire                 pop_valid,
    input  wire                 last,
    // lane partials, already one cycle behind the pop
    input  wire vote_pkg::partial_t partial_lo,
    input  wire vote_pkg::partial_t partial_hi,
    // one cycle pulse, no ready
    output logic                result_valid,
    output vote_pkg::tally_result_t result
);

    localparam int ACC_W = `VT_ACC_W;
    localparam int CNT_W = `VT_CNT_W;

    // control delayed to meet the lane registers
    logic valid_d;
    logic last_d;

    // running state of the open group
    logic signed [ACC_W-1:0] total;
    logic [CNT_W-1:0]        count;

    // both halves, sign extended to total width
    logic signed [ACC_W-1:0] pair_sum;
    logic signed [ACC_W-1:0] next_total;
    logic [CNT_W-1:0]        next_count;

    logic group_done;

    assign pair_sum   = ACC_W'(partial_lo.sum) + ACC_W'(partial_hi.sum);
    assign next_total = total + pair_sum;
    // count includes the batch being added
    assign next_count = count + 1'b1;
    assign group_done = valid_d && last_d;

    // alignment stage
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d <= 1'b0;
            last_d  <= 1'b0;
        end else begin
            valid_d <= pop_valid;
            last_d  <= last;
        end
    end

    // running total and batch count
    always_ff @(posedge clk) begin
        if (rst) begin
            total        <= '0;
            count        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= group_done;
            if (valid_d) begin
                if (last_d) begin
                    // group closes, restart from zero
                    total <= '0;
                    count <= '0;
                end else begin
                    total <= next_total;
                    count <= next_count;
                end
            end
        end
    end

    // result word, only meaningful with result_valid
    always_ff @(posedge clk) begin
        if (group_done) begin
            result.total <= next_total;
            result.sign  <= next_total[ACC_W-1];
            result.count <= next_count;
        end
    end

endmodule

`default_nettype wire

// File: vote_credit_fifo.sv
`include "vote_defs.svh"

`default_nettype none

module vote_credit_fifo (
    input  wire                  clk,
    input  wire                  rst,
    // sender side, only valid while it holds a credit
    input  wire                  batch_valid,
    input  wire vote_pkg::vote_batch_t batch,
    // drain side, pops on its own whenever data is held
    output logic                 pop_valid,
    output vote_pkg::vote_batch_t pop_batch,
    // one pulse per popped entry
    output logic                 credit
);

    localparam int DEPTH = `VT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage, payload only
    vote_pkg::vote_batch_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // pop whenever anything is held
    assign pop  = (count != '0);
    assign push = batch_valid;

    // head entry goes straight out, no output register
    assign pop_valid = pop;
    assign pop_batch = mem[rd_ptr];

    // credit returned in the same cycle as the pop
    assign credit = pop;

    // storage write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= batch;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // wrap at depth, need not be a power of two
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: vote_defs.svh
`ifndef VOTE_DEFS_SVH
`define VOTE_DEFS_SVH

// number of cores in the array
// must stay even, the array is split into two lane halves
`define VT_CORES 16

// signed running total width
// wide enough that a group can never overflow it
`define VT_ACC_W 30

// batch counter width, batches per group
`define VT_CNT_W 16

// input fifo entries
// the sender also starts with this many credits
`define VT_FIFO_DEPTH 4

`endif

// File: vote_pkg.sv
`include "vote_defs.svh"

package vote_pkg;

    // one half of the cores, plus sign and one bit of headroom
    // 5 bits for 16 cores, covers -8 .. +8
    localparam int PART_W = $clog2(`VT_CORES / 2) + 2;

    // one round as sent by the cores
    typedef struct packed {
        logic [`VT_CORES-1:0] store;
        logic [`VT_CORES-1:0] result;
        logic                 last;
    } vote_batch_t;

    // signed vote sum of one lane half
    typedef struct packed {
        logic signed [PART_W-1:0] sum;
    } partial_t;

    // result of one finished group
    typedef struct packed {
        logic signed [`VT_ACC_W-1:0] total;
        logic                        sign;
        logic [`VT_CNT_W-1:0]        count;
    } tally_result_t;

endpackage

// File: vote_tally_sva.sv
`include "vote_defs.svh"

module vote_tally_sva (
    input wire clk,
    input wire rst,
    input wire batch_valid,
    input wire credit,
    input wire pop_valid,
    input wire result_valid
);

    localparam int DEPTH = `VT_FIFO_DEPTH;

    // shadow fifo occupancy from pushes and credit pulses
    int occupancy;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + (batch_valid ? 1 : 0) - (credit ? 1 : 0);
        end
    end

    push_not_full: assert property (@(posedge clk) disable iff (rst)
        batch_valid |-> (occupancy < DEPTH))
        else $error("batch pushed while the input fifo was full");

    // a credit needs a pop of an entry the sender really pushed
    credit_with_pop: assert property (@(posedge clk) disable iff (rst)
        credit |-> (pop_valid && occupancy > 0))
        else $error("credit pulse without a pop of a held entry");

    // first cycle out of reset must be quiet
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!credit && !result_valid))
        else $error("credit or result_valid high right after reset");

endmodule

bind vote_tally_top vote_tally_sva vote_tally_sva_inst (
    .clk          (clk),
    .rst          (rst),
    .batch_valid  (batch_valid),
    .credit       (credit),
    .pop_valid    (pop_valid),
    .result_valid (result_valid)
);

// File: vote_tally_top.sv
`include "vote_defs.svh"

`default_nettype none

module vote_tally_top (
    input  wire                      clk,
    input  wire                      rst,
    // credit controlled input
    input  wire                      batch_valid,
    input  wire vote_pkg::vote_batch_t batch,
    output logic                     credit,
    // group results, one cycle pulse each
    output logic                     result_valid,
    output vote_pkg::tally_result_t  result
);

    localparam int HALF = `VT_CORES / 2;

    // popped round
    logic                  pop_valid;
    vote_pkg::vote_batch_t pop_batch;

    // per half sums
    vote_pkg::partial_t partial_lo;
    vote_pkg::partial_t partial_hi;

    // input buffer and credit return
    vote_credit_fifo vote_credit_fifo_inst (
        .clk         (clk),
        .rst         (rst),
        .batch_valid (batch_valid),
        .batch       (batch),
        .pop_valid   (pop_valid),
        .pop_batch   (pop_batch),
        .credit      (credit)
    );

    // lower cores
    lane_tally #(
        .LANES (HALF)
    ) lane_tally_lo_inst (
        .clk     (clk),
        .rst     (rst),
        .store   (pop_batch.store[HALF-1:0]),
        .result  (pop_batch.result[HALF-1:0]),
        .partial (partial_lo)
    );

    // upper cores
    lane_tally #(
        .LANES (HALF)
    ) lane_tally_hi_inst (
        .clk     (clk),
        .rst     (rst),
        .store   (pop_batch.store[`VT_CORES-1:HALF]),
        .result  (pop_batch.result[`VT_CORES-1:HALF]),
        .partial (partial_hi)
    );

    // group total and result pulse
    vote_accumulator vote_accumulator_inst (
        .clk          (clk),
        .rst          (rst),
        .pop_valid    (pop_valid),
        .last         (pop_batch.last),
        .partial_lo   (partial_lo),
        .partial_hi   (partial_hi),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire
